//--- logic/rename_types_pkg.sv
`default_nettype none

package rename_types_pkg;

    // Register file sizing
    localparam int NUM_ARCH = 32;
    localparam int NUM_PHYS = 64;

    // Dispatch and commit slots per cycle
    localparam int WIDTH = 2;

    localparam int ARCH_W = $clog2(NUM_ARCH);
    localparam int PHYS_W = $clog2(NUM_PHYS);

    typedef logic [ARCH_W-1:0] arch_reg_t;  // x0..x31
    typedef logic [PHYS_W-1:0] phys_reg_t;  // p0..p63, p0 is x0 forever

endpackage

`default_nettype wire

//--- logic/rename_bus_pkg.sv
`default_nettype none

package rename_bus_pkg;

    // One instruction entering rename
    typedef struct packed {
        logic                        valid;
        logic                        has_rd;
        rename_types_pkg::arch_reg_t rd;
        rename_types_pkg::arch_reg_t rs1;
        rename_types_pkg::arch_reg_t rs2;
    } dispatch_slot_t;

    // One instruction leaving rename
    typedef struct packed {
        logic                        valid;
        logic                        has_rd;
        rename_types_pkg::phys_reg_t pd;
        rename_types_pkg::phys_reg_t old_pd;  // Freed when this one commits
        rename_types_pkg::phys_reg_t ps1;
        rename_types_pkg::phys_reg_t ps2;
    } renamed_slot_t;

    // One retiring instruction
    typedef struct packed {
        logic                        valid;
        rename_types_pkg::arch_reg_t rd;
        rename_types_pkg::phys_reg_t pd;
        rename_types_pkg::phys_reg_t old_pd;
    } commit_slot_t;

    typedef enum logic {
        run,
        recover
    } stage_state_e;

endpackage

`default_nettype wire

//--- logic/phys_freelist.sv
`timescale 1ns/100ps
`default_nettype none

module phys_freelist #(
    parameter int FREE_DEPTH = 32
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic                        push2,
    input  rename_types_pkg::phys_reg_t push_tag [rename_types_pkg::WIDTH],
    input  logic                        pop,
    input  logic                        pop2,
    input  logic                        flush,
    output rename_types_pkg::phys_reg_t pop_tag [rename_types_pkg::WIDTH],
    output logic                        has_two
);

    localparam int IDX_W = $clog2(FREE_DEPTH);
    // Tags free after reset, p32..p63
    localparam int INIT_FREE = rename_types_pkg::NUM_PHYS - rename_types_pkg::NUM_ARCH;

    // Extra top bit tells full from empty
    typedef logic [IDX_W:0] ptr_t;

    rename_types_pkg::phys_reg_t entries [FREE_DEPTH];

    ptr_t alloc_ptr;  // Next tag handed to dispatch
    ptr_t rel_ptr;    // Next slot for a freed tag
    ptr_t alloc_bkp;  // Allocation point as seen by retirement
    ptr_t push_cnt;
    ptr_t pop_cnt;
    ptr_t free_cnt;

    logic [IDX_W-1:0] alloc_idx;
    logic [IDX_W-1:0] alloc_idx1;
    logic [IDX_W-1:0] rel_idx;
    logic [IDX_W-1:0] rel_idx1;

    assign push_cnt = ptr_t'(push) + ptr_t'(push2);
    assign pop_cnt  = ptr_t'(pop) + ptr_t'(pop2);
    assign free_cnt = rel_ptr - alloc_ptr;
    assign has_two  = free_cnt >= ptr_t'(2);

    assign alloc_idx  = alloc_ptr[IDX_W-1:0];
    assign alloc_idx1 = alloc_idx + 1'b1;  // Wraps with the array
    assign rel_idx    = rel_ptr[IDX_W-1:0];
    assign rel_idx1   = rel_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_ptr <= '0;
            alloc_bkp <= '0;
            rel_ptr   <= ptr_t'(INIT_FREE);
        end else begin
            rel_ptr   <= rel_ptr + push_cnt;
            // Every commit that frees a tag also retires one allocation
            alloc_bkp <= alloc_bkp + push_cnt;
            if (flush) begin
                alloc_ptr <= alloc_bkp + push_cnt;  // Drop speculative pops
            end else begin
                alloc_ptr <= alloc_ptr + pop_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < INIT_FREE; i++) begin
                entries[i] <= rename_types_pkg::phys_reg_t'(rename_types_pkg::NUM_ARCH + i);
            end
        end else begin
            if (push) begin
                entries[rel_idx] <= push_tag[0];
            end
            if (push2) begin
                entries[push ? rel_idx1 : rel_idx] <= push_tag[1];  // Packs to the tail
            end
        end
    end

    // Slot 1 alone takes the head entry
    always_ff @(posedge clk) begin
        if (pop) begin
            pop_tag[0] <= entries[alloc_idx];
        end
        if (pop2) begin
            pop_tag[1] <= entries[pop ? alloc_idx1 : alloc_idx];
        end
    end

    // Rename must stall before the list runs dry
    pop_needs_two: assert property (
        @(posedge clk) disable iff (rst) (pop || pop2) |-> has_two
    ) else $error("phys_freelist: pop with fewer than two free tags");

    // More frees than allocations would mean a tag was released twice
    no_overfill: assert property (
        @(posedge clk) disable iff (rst) free_cnt <= ptr_t'(FREE_DEPTH)
    ) else $error("phys_freelist: free count above depth");

endmodule

`default_nettype wire

//--- logic/rename_map.sv
`timescale 1ns/100ps
`default_nettype none

module rename_map (
    input  logic                                   clk,
    input  logic                                   rst,
    input  rename_types_pkg::arch_reg_t            src_idx     [2*rename_types_pkg::WIDTH],
    input  rename_types_pkg::arch_reg_t            dst_idx     [rename_types_pkg::WIDTH],
    input  logic [rename_types_pkg::WIDTH-1:0]     wr_en,
    input  rename_types_pkg::arch_reg_t            wr_idx      [rename_types_pkg::WIDTH],
    input  rename_types_pkg::phys_reg_t            wr_tag      [rename_types_pkg::WIDTH],
    input  logic                                   restore,
    input  rename_types_pkg::phys_reg_t            restore_map [rename_types_pkg::NUM_ARCH],
    output rename_types_pkg::phys_reg_t            src_tag     [2*rename_types_pkg::WIDTH],
    output rename_types_pkg::phys_reg_t            dst_tag     [rename_types_pkg::WIDTH]
);

    rename_types_pkg::phys_reg_t map_q [rename_types_pkg::NUM_ARCH];

    // Plain table lookups, no bypass here
    always_comb begin
        for (int s = 0; s < 2*rename_types_pkg::WIDTH; s++) begin
            src_tag[s] = map_q[src_idx[s]];
        end
        for (int d = 0; d < rename_types_pkg::WIDTH; d++) begin
            dst_tag[d] = map_q[dst_idx[d]];  // Becomes old_pd
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_types_pkg::NUM_ARCH; i++) begin
                map_q[i] <= rename_types_pkg::phys_reg_t'(i);  // Identity map
            end
        end else if (restore) begin
            // Entry 0 stays at p0
            for (int i = 1; i < rename_types_pkg::NUM_ARCH; i++) begin
                map_q[i] <= restore_map[i];
            end
        end else begin
            // Later slot is younger, so it lands last
            for (int w = 0; w < rename_types_pkg::WIDTH; w++) begin
                if (wr_en[w] && wr_idx[w] != '0) begin
                    map_q[wr_idx[w]] <= wr_tag[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/commit_map.sv
`timescale 1ns/100ps
`default_nettype none

module commit_map (
    input  logic                          clk,
    input  logic                          rst,
    input  rename_bus_pkg::commit_slot_t  commit        [rename_types_pkg::WIDTH],
    output rename_types_pkg::phys_reg_t   committed_map [rename_types_pkg::NUM_ARCH]
);

    rename_types_pkg::phys_reg_t map_q [rename_types_pkg::NUM_ARCH];

    // Output includes this cycle's commits so a flush sees them
    always_comb begin
        committed_map = map_q;
        for (int w = 0; w < rename_types_pkg::WIDTH; w++) begin
            if (commit[w].valid && commit[w].rd != '0) begin
                committed_map[commit[w].rd] = commit[w].pd;  // Slot 1 wins
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_types_pkg::NUM_ARCH; i++) begin
                map_q[i] <= rename_types_pkg::phys_reg_t'(i);
            end
        end else begin
            map_q <= committed_map;
        end
    end

    // p0 belongs to x0 and is never allocated by rename
    for (genvar w = 0; w < rename_types_pkg::WIDTH; w++) begin : g_chk
        commit_pd_nonzero: assert property (
            @(posedge clk) disable iff (rst)
            (commit[w].valid && commit[w].rd != '0) |-> (commit[w].pd != '0)
        ) else $error("commit_map: slot %0d commits p0 for a nonzero rd", w);
    end

endmodule

`default_nettype wire

//--- logic/rename_stage.sv
`timescale 1ns/100ps
`default_nettype none

module rename_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  rename_bus_pkg::dispatch_slot_t      dispatch   [rename_types_pkg::WIDTH],
    input  logic                                flush,
    input  logic                                has_two,
    input  rename_types_pkg::phys_reg_t         pop_tag    [rename_types_pkg::WIDTH],
    input  rename_types_pkg::phys_reg_t         src_tag    [2*rename_types_pkg::WIDTH],
    input  rename_types_pkg::phys_reg_t         dst_tag    [rename_types_pkg::WIDTH],
    output logic                                ready,
    output logic                                pop,
    output logic                                pop2,
    output rename_bus_pkg::renamed_slot_t       renamed    [rename_types_pkg::WIDTH],
    output logic [rename_types_pkg::WIDTH-1:0]  map_wr_en,
    output rename_types_pkg::arch_reg_t         map_wr_idx [rename_types_pkg::WIDTH],
    output rename_types_pkg::phys_reg_t         map_wr_tag [rename_types_pkg::WIDTH],
    output logic                                restore
);

    localparam int W = rename_types_pkg::WIDTH;

    rename_bus_pkg::stage_state_e state;

    logic         accept;
    logic [W-1:0] alloc;
    logic [W-1:0] alloc_q;
    logic [W-1:0] valid_q;
    logic [W-1:0] has_rd_q;
    logic         hit_rs1_q;  // Slot 1 source from slot 0 pd
    logic         hit_rs2_q;
    logic         hit_old_q;  // Slot 1 overwrites slot 0 rd

    rename_types_pkg::arch_reg_t src_idx [2*W];
    rename_types_pkg::arch_reg_t rd_q    [W];
    rename_types_pkg::phys_reg_t src_fwd [2*W];
    rename_types_pkg::phys_reg_t dst_fwd [W];
    rename_types_pkg::phys_reg_t ps_q    [2*W];
    rename_types_pkg::phys_reg_t old_q   [W];

    assign ready  = (state == rename_bus_pkg::run) && has_two && !flush;
    assign accept = ready && (dispatch[0].valid || dispatch[1].valid);

    always_comb begin
        for (int i = 0; i < W; i++) begin
            alloc[i] = accept && dispatch[i].valid && dispatch[i].has_rd
                       && dispatch[i].rd != '0;  // x0 never takes a tag
        end
    end

    assign pop     = alloc[0];
    assign pop2    = alloc[1];
    assign restore = flush;

    // Previous bundle writes the map this cycle
    assign map_wr_en = alloc_q;
    always_comb begin
        for (int i = 0; i < W; i++) begin
            map_wr_idx[i] = rd_q[i];
            map_wr_tag[i] = pop_tag[i];
        end
    end

    // Table reads miss the write landing now, so bypass it
    always_comb begin
        for (int i = 0; i < W; i++) begin
            src_idx[2*i]   = dispatch[i].rs1;
            src_idx[2*i+1] = dispatch[i].rs2;
        end
        for (int s = 0; s < 2*W; s++) begin
            src_fwd[s] = src_tag[s];
            for (int w = 0; w < W; w++) begin
                if (map_wr_en[w] && rd_q[w] == src_idx[s]) begin
                    src_fwd[s] = pop_tag[w];
                end
            end
        end
        for (int d = 0; d < W; d++) begin
            dst_fwd[d] = dst_tag[d];
            for (int w = 0; w < W; w++) begin
                if (map_wr_en[w] && rd_q[w] == dispatch[d].rd) begin
                    dst_fwd[d] = pop_tag[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= rename_bus_pkg::run;
            valid_q <= '0;
            alloc_q <= '0;
        end else begin
            state   <= flush ? rename_bus_pkg::recover : rename_bus_pkg::run;
            valid_q <= {accept && dispatch[1].valid, accept && dispatch[0].valid};
            alloc_q <= alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < W; i++) begin
                rd_q[i]     <= dispatch[i].rd;
                has_rd_q[i] <= dispatch[i].has_rd;
                old_q[i]    <= dst_fwd[i];
            end
            for (int s = 0; s < 2*W; s++) begin
                ps_q[s] <= src_fwd[s];
            end
            hit_rs1_q <= alloc[0] && dispatch[1].rs1 == dispatch[0].rd;
            hit_rs2_q <= alloc[0] && dispatch[1].rs2 == dispatch[0].rd;
            hit_old_q <= alloc[0] && dispatch[1].rd == dispatch[0].rd;
        end
    end

    // New pd arrives with pop_tag, one cycle after acceptance
    always_comb begin
        for (int i = 0; i < W; i++) begin
            renamed[i].valid  = valid_q[i];
            renamed[i].has_rd = has_rd_q[i];
            renamed[i].pd     = alloc_q[i] ? pop_tag[i] : '0;
            renamed[i].old_pd = alloc_q[i] ? old_q[i] : '0;
            renamed[i].ps1    = ps_q[2*i];
            renamed[i].ps2    = ps_q[2*i+1];
        end
        if (hit_rs1_q) begin
            renamed[1].ps1 = pop_tag[0];
        end
        if (hit_rs2_q) begin
            renamed[1].ps2 = pop_tag[0];
        end
        if (hit_old_q && alloc_q[1]) begin
            renamed[1].old_pd = pop_tag[0];
        end
    end

    // A new mapping never points at p0
    for (genvar i = 0; i < W; i++) begin : g_chk
        wr_tag_nonzero: assert property (
            @(posedge clk) disable iff (rst)
            map_wr_en[i] |-> map_wr_tag[i] != '0
        ) else $error("rename_stage: slot %0d maps a register to p0", i);
    end

endmodule

`default_nettype wire

//--- logic/rename_unit.sv
`timescale 1ns/100ps
`default_nettype none

module rename_unit #(
    parameter int FREE_DEPTH = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  rename_bus_pkg::dispatch_slot_t dispatch [rename_types_pkg::WIDTH],
    output logic                           ready,
    output rename_bus_pkg::renamed_slot_t  renamed  [rename_types_pkg::WIDTH],
    input  rename_bus_pkg::commit_slot_t   commit   [rename_types_pkg::WIDTH],
    input  logic                           flush
);

    localparam int W = rename_types_pkg::WIDTH;

    logic         has_two;
    logic         pop;
    logic         pop2;
    logic         push;
    logic         push2;
    logic         restore;
    logic [W-1:0] map_wr_en;

    rename_types_pkg::arch_reg_t src_idx       [2*W];
    rename_types_pkg::arch_reg_t dst_idx       [W];
    rename_types_pkg::arch_reg_t map_wr_idx    [W];
    rename_types_pkg::phys_reg_t src_tag       [2*W];
    rename_types_pkg::phys_reg_t dst_tag       [W];
    rename_types_pkg::phys_reg_t pop_tag       [W];
    rename_types_pkg::phys_reg_t push_tag      [W];
    rename_types_pkg::phys_reg_t map_wr_tag    [W];
    rename_types_pkg::phys_reg_t committed_map [rename_types_pkg::NUM_ARCH];

    for (genvar i = 0; i < W; i++) begin : g_slot
        assign src_idx[2*i]   = dispatch[i].rs1;
        assign src_idx[2*i+1] = dispatch[i].rs2;
        assign dst_idx[i]     = dispatch[i].rd;
        assign push_tag[i]    = commit[i].old_pd;  // Previous mapping goes back
    end

    assign push  = commit[0].valid && commit[0].rd != '0;
    assign push2 = commit[1].valid && commit[1].rd != '0;

    phys_freelist #(
        .FREE_DEPTH (FREE_DEPTH)
    ) phys_freelist_i (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push2    (push2),
        .push_tag (push_tag),
        .pop      (pop),
        .pop2     (pop2),
        .flush    (flush),
        .pop_tag  (pop_tag),
        .has_two  (has_two)
    );

    rename_map rename_map_i (
        .clk         (clk),
        .rst         (rst),
        .src_idx     (src_idx),
        .dst_idx     (dst_idx),
        .wr_en       (map_wr_en),
        .wr_idx      (map_wr_idx),
        .wr_tag      (map_wr_tag),
        .restore     (restore),
        .restore_map (committed_map),
        .src_tag     (src_tag),
        .dst_tag     (dst_tag)
    );

    commit_map commit_map_i (
        .clk           (clk),
        .rst           (rst),
        .commit        (commit),
        .committed_map (committed_map)
    );

    rename_stage rename_stage_i (
        .clk        (clk),
        .rst        (rst),
        .dispatch   (dispatch),
        .flush      (flush),
        .has_two    (has_two),
        .pop_tag    (pop_tag),
        .src_tag    (src_tag),
        .dst_tag    (dst_tag),
        .ready      (ready),
        .pop        (pop),
        .pop2       (pop2),
        .renamed    (renamed),
        .map_wr_en  (map_wr_en),
        .map_wr_idx (map_wr_idx),
        .map_wr_tag (map_wr_tag),
        .restore    (restore)
    );

endmodule

`default_nettype wire

//--- testbench/tb_rename_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rename_unit;

    localparam int W = rename_types_pkg::WIDTH;

    logic clk = 1'b0;
    logic rst;
    logic ready;
    logic flush;

    rename_bus_pkg::dispatch_slot_t dispatch [W];
    rename_bus_pkg::renamed_slot_t  renamed  [W];
    rename_bus_pkg::commit_slot_t   commit   [W];

    // Reference model of the rename block
    rename_types_pkg::phys_reg_t    spec_map [rename_types_pkg::NUM_ARCH];
    rename_types_pkg::phys_reg_t    comm_map [rename_types_pkg::NUM_ARCH];
    rename_types_pkg::phys_reg_t    free_q [$];
    rename_types_pkg::phys_reg_t    rewind_q [$];    // Free tags as retirement sees them
    rename_bus_pkg::commit_slot_t   inflight_q [$];  // Renamed, waiting to retire
    rename_bus_pkg::dispatch_slot_t bundle [W];      // Held until accepted
    rename_bus_pkg::renamed_slot_t  exp_out [W];
    rename_types_pkg::arch_reg_t    exp_rd [W];

    logic   recovering;
    logic   accepted;
    logic   ready_seen;
    integer seed = 32'hcc72;
    int     checks = 0;
    int     errors = 0;

    always #4 clk = ~clk;

    rename_unit #(
        .FREE_DEPTH (32)
    ) rename_unit_i (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .ready    (ready),
        .renamed  (renamed),
        .commit   (commit),
        .flush    (flush)
    );

    task automatic check_slot(input int idx, input rename_bus_pkg::renamed_slot_t got,
                              input rename_bus_pkg::renamed_slot_t exp);
        logic bad;
        bad = exp.valid ? (got !== exp) : (got.valid !== 1'b0);  // Idle slot fields are free
        checks++;
        if (bad) begin
            errors++;
            $display("Fail at %0t: renamed[%0d] got %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: ready got %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < rename_types_pkg::NUM_ARCH; i++) begin
            spec_map[i] = rename_types_pkg::phys_reg_t'(i);
            comm_map[i] = rename_types_pkg::phys_reg_t'(i);
        end
        free_q.delete();
        for (int t = 32; t < rename_types_pkg::NUM_PHYS; t++) begin
            free_q.push_back(rename_types_pkg::phys_reg_t'(t));
        end
        rewind_q = free_q;
        inflight_q.delete();
        exp_out[0] = '0;
        exp_out[1] = '0;
        recovering = 1'b0;
        accepted   = 1'b0;
    endtask

    task automatic set_slot(input int i, input logic has_rd, input int rd,
                            input int rs1, input int rs2);
        bundle[i].valid  = 1'b1;
        bundle[i].has_rd = has_rd;
        bundle[i].rd     = rename_types_pkg::arch_reg_t'(rd);
        bundle[i].rs1    = rename_types_pkg::arch_reg_t'(rs1);
        bundle[i].rs2    = rename_types_pkg::arch_reg_t'(rs2);
    endtask

    // Small span forces matches inside and across bundles
    task automatic make_bundle(input int span, input int idle_pct);
        for (int i = 0; i < W; i++) begin
            bundle[i].valid  = ($unsigned($random(seed)) % 100) >= idle_pct;
            bundle[i].has_rd = ($random(seed) & 3) != 0;
            bundle[i].rd     = rename_types_pkg::arch_reg_t'($unsigned($random(seed)) % span);
            bundle[i].rs1    = rename_types_pkg::arch_reg_t'($unsigned($random(seed)) % span);
            bundle[i].rs2    = rename_types_pkg::arch_reg_t'($unsigned($random(seed)) % span);
        end
    endtask

    // One clock cycle: drive, check, then advance the model
    task automatic step(input logic fl, input int max_commit);
        rename_bus_pkg::commit_slot_t  cs [W];
        rename_bus_pkg::commit_slot_t  c;
        rename_bus_pkg::renamed_slot_t e;
        logic exp_ready;
        int   n;
        n = $unsigned($random(seed)) % (max_commit + 1);
        for (int k = 0; k < W; k++) begin
            cs[k] = '0;
            if (k < n && inflight_q.size() > 0) begin
                cs[k] = inflight_q.pop_front();  // Oldest first
            end
        end
        @(posedge clk);
        for (int k = 0; k < W; k++) begin
            dispatch[k] <= bundle[k];
            commit[k]   <= cs[k];
        end
        flush <= fl;
        @(negedge clk);
        exp_ready  = !recovering && !fl && free_q.size() >= 2;
        ready_seen = ready;
        check_ready(ready, exp_ready);
        for (int i = 0; i < W; i++) begin
            check_slot(i, renamed[i], exp_out[i]);
            if (exp_out[i].valid && !fl) begin  // Squashed by a flush otherwise
                c.valid  = 1'b1;
                c.rd     = exp_rd[i];
                c.pd     = exp_out[i].pd;
                c.old_pd = exp_out[i].old_pd;
                inflight_q.push_back(c);
            end
        end
        accepted = exp_ready && (bundle[0].valid || bundle[1].valid);
        for (int i = 0; i < W; i++) begin
            e         = '0;
            exp_rd[i] = '0;
            if (accepted && bundle[i].valid) begin
                e.valid  = 1'b1;
                e.has_rd = bundle[i].has_rd;
                e.ps1    = spec_map[bundle[i].rs1];
                e.ps2    = spec_map[bundle[i].rs2];
                if (bundle[i].has_rd && bundle[i].rd != '0) begin
                    e.pd      = free_q.pop_front();
                    e.old_pd  = spec_map[bundle[i].rd];
                    exp_rd[i] = bundle[i].rd;
                    spec_map[bundle[i].rd] = e.pd;
                end
            end
            exp_out[i] = e;
        end
        for (int k = 0; k < W; k++) begin
            if (cs[k].valid && cs[k].rd != '0) begin
                comm_map[cs[k].rd] = cs[k].pd;
                free_q.push_back(cs[k].old_pd);
                void'(rewind_q.pop_front());  // Retires the allocation of this pd
                rewind_q.push_back(cs[k].old_pd);
            end
        end
        if (fl) begin
            spec_map = comm_map;
            free_q   = rewind_q;
            inflight_q.delete();
        end
        recovering = fl;
    endtask

    task automatic send_bundle(input int max_commit);
        int   waited;
        logic idle;
        waited = 0;
        idle   = !(bundle[0].valid || bundle[1].valid);  // Empty bundle is one idle cycle
        step(1'b0, max_commit);
        while (!idle && !accepted && waited < 64) begin
            waited++;
            step(1'b0, max_commit);
        end
        if (!idle && !accepted) begin
            errors++;
            $display("Timeout at %0t: bundle not accepted within 64 cycles", $time);
        end
        bundle[0].valid = 1'b0;
        bundle[1].valid = 1'b0;
    endtask

    task automatic retire_all();
        int waited;
        waited = 0;
        step(1'b0, 2);
        while (inflight_q.size() > 0 && waited < 200) begin
            waited++;
            step(1'b0, 2);
        end
        if (inflight_q.size() > 0) begin
            errors++;
            $display("Timeout at %0t: renamed instructions did not retire", $time);
        end
    endtask

    initial begin
        int waited;
        rst   = 1'b1;
        flush = 1'b0;
        for (int k = 0; k < W; k++) begin
            dispatch[k] = '0;
            commit[k]   = '0;
            bundle[k]   = '0;
        end
        reset_model();
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Identity reads of x0..x31, no destinations
        for (int b = 0; b < 8; b++) begin
            set_slot(0, 1'b0, 0, 4*b, 4*b + 1);
            set_slot(1, 1'b0, 0, 4*b + 2, 4*b + 3);
            send_bundle(0);
        end
        set_slot(0, 1'b1, 5, 1, 2);
        set_slot(1, 1'b1, 9, 5, 9);  // Reads slot 0 result
        send_bundle(0);
        set_slot(0, 1'b1, 5, 5, 9);  // Previous bundle still landing in the map
        set_slot(1, 1'b1, 5, 5, 0);
        send_bundle(0);

        for (int b = 0; b < 150; b++) begin
            make_bundle(4, 10);
            send_bundle(2);
        end

        // Long random run with idle cycles and rare flushes
        make_bundle(32, 20);
        for (int c = 0; c < 1500; c++) begin
            step(($unsigned($random(seed)) % 64) == 0, 2);
            if (accepted || !(bundle[0].valid || bundle[1].valid)) begin
                make_bundle(32, 20);
            end
        end

        // Allocate without retiring until ready drops
        bundle[0].valid = 1'b0;
        bundle[1].valid = 1'b0;
        ready_seen      = 1'b1;
        waited          = 0;
        while (ready_seen && waited < 100) begin
            if (accepted || !(bundle[0].valid || bundle[1].valid)) begin
                make_bundle(32, 0);
                for (int i = 0; i < W; i++) begin
                    bundle[i].has_rd = 1'b1;
                    bundle[i].rd[0]  = 1'b1;
                end
            end
            step(1'b0, 0);
            waited++;
        end
        if (ready_seen) begin
            errors++;
            $display("Timeout at %0t: ready stayed high with the free list drained", $time);
        end
        bundle[0].valid = 1'b0;
        bundle[1].valid = 1'b0;
        waited          = 0;
        step(1'b0, 2);
        while (!ready_seen && waited < 100) begin
            waited++;
            step(1'b0, 2);
        end
        if (!ready_seen) begin
            errors++;
            $display("Timeout at %0t: ready did not return after commits", $time);
        end

        // Flush with uncommitted work in flight
        retire_all();
        for (int b = 0; b < 3; b++) begin
            make_bundle(8, 0);
            send_bundle(0);
        end
        make_bundle(8, 0);
        step(1'b1, 2);  // Held bundle is ignored here
        send_bundle(2);
        for (int b = 0; b < 20; b++) begin
            make_bundle(32, 0);
            send_bundle(1);
        end
        retire_all();
        repeat (4) step(1'b0, 0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/rename_types_pkg.sv
logic/rename_bus_pkg.sv
logic/phys_freelist.sv
logic/rename_map.sv
logic/commit_map.sv
logic/rename_stage.sv
logic/rename_unit.sv
testbench/tb_rename_unit.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_rename_unit
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)
